//--- list.f
source/spart_pkg.sv
source/spart_bus_if.sv
source/spart_driver.sv
source/spart_bus_ctrl.sv
source/spart_baud_gen.sv
source/spart_tx.sv
source/spart_rx.sv
source/spart_system.sv
test/spart_system_chk.sv
test/spart_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module spart_system_tb \
	-f list.f \
	--Mdir obj_dir -o spart_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Let every assertion failure through so the testbench can count it
output=$(./obj_dir/spart_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
exit 1

//--- source/spart_baud_gen.sv
`timescale 1ns/1ns

module spart_baud_gen import spart_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  div_t div,
	output logic tick
);

	// Clocks left until the next tick
	div_t cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= 1'b0;
			// Silent until programmed
			if (div == '0)
				cnt <= '0;
			else if (cnt == '0)
			begin
				cnt  <= div - 1'b1;
				tick <= 1'b1;
			end
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

//--- source/spart_bus_ctrl.sv
`timescale 1ns/1ns

module spart_bus_ctrl import spart_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     tx_busy,
	input  byte_t    rx_byte,
	input  logic     rx_done,
	output div_t     div,
	output byte_t    tx_byte,
	output logic     tx_load,
	spart_bus_if.dev bus
);

	// Access strobes
	logic wr_en;
	logic rd_data;

	// Divisor halves
	byte_t div_lo;
	byte_t div_hi;

	// One byte each way
	byte_t tx_buf;
	byte_t rx_buf;
	logic  tx_full;
	logic  rda_q;

	assign wr_en = bus.iocs & ~bus.iorw;
	assign rd_data = bus.iocs & bus.iorw & (bus.ioaddr == ADDR_DATA);

	// Pass the byte on as soon as the transmitter is free
	assign tx_load = tx_full & ~tx_busy;
	assign tx_byte = tx_buf;
	assign div     = {div_hi, div_lo};

	assign bus.tbr = ~tx_full;
	assign bus.rda = rda_q;

	//////////////////////////////////////////////////
	// Register writes and flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_lo  <= '0;
			div_hi  <= '0;
			tx_full <= 1'b0;
			rda_q   <= 1'b0;
		end
		else
		begin
			if (tx_load)
				tx_full <= 1'b0;
			// A new write after the load keeps the buffer full
			if (wr_en)
			begin
				case (bus.ioaddr)
					ADDR_DATA:   tx_full <= 1'b1;
					ADDR_DIV_LO: div_lo <= bus.wdata;
					ADDR_DIV_HI: div_hi <= bus.wdata;
					default:     ;
				endcase
			end
			// Fresh byte wins over the read clear
			if (rd_data)
				rda_q <= 1'b0;
			if (rx_done)
				rda_q <= 1'b1;
		end
	end

	// Byte buffers
	always_ff @(posedge clk)
	begin
		if (wr_en && bus.ioaddr == ADDR_DATA)
			tx_buf <= bus.wdata;
		if (rx_done)
			rx_buf <= rx_byte;
	end

	// Read mux, status is {rda, tbr}
	always_comb
	begin
		case (bus.ioaddr)
			ADDR_STATUS: bus.rdata = {6'b0, rda_q, ~tx_full};
			ADDR_DIV_LO: bus.rdata = div_lo;
			ADDR_DIV_HI: bus.rdata = div_hi;
			default:     bus.rdata = rx_buf;
		endcase
	end

endmodule

//--- source/spart_bus_if.sv
`timescale 1ns/1ns

interface spart_bus_if import spart_pkg::*; ();

	// Driver side of the register bus
	logic     iocs;
	logic     iorw;
	io_addr_t ioaddr;
	byte_t    wdata;

	// Core side, read data and buffer flags
	byte_t    rdata;
	logic     rda;
	logic     tbr;

	// Bus master
	modport drv (
		output iocs, iorw, ioaddr, wdata,
		input  rdata, rda, tbr
	);

	// Register block
	modport dev (
		input  iocs, iorw, ioaddr, wdata,
		output rdata, rda, tbr
	);

endinterface

//--- source/spart_driver.sv
`timescale 1ns/1ns

module spart_driver import spart_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         word_wr,
	input  logic         word_rd,
	input  word_t        word_tx,
	output word_t        word_rx,
	output logic         req_ack,
	output word_status_t status,
	spart_bus_if.drv     bus
);

	drv_state_t state;

	// Divisor already written
	logic div_set;

	// One word operation outstanding at a time
	logic wr_pend;
	logic rd_pend;
	logic busy;
	logic accept_wr;
	logic accept_rd;

	// Byte lane counters
	logic [1:0] wr_cnt;
	logic [1:0] rd_cnt;

	// Outgoing word and partly assembled incoming word
	word_t tx_word;
	word_t rx_asm;

	//////////////////////////////////////////////////
	// Host request handling
	//////////////////////////////////////////////////

	assign busy = wr_pend | rd_pend;
	assign accept_wr = word_wr & ~busy;
	// Write wins if both come together
	assign accept_rd = word_rd & ~word_wr & ~busy;

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= IDLE;
			div_set <= 1'b0;
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
			wr_cnt  <= 2'd0;
			rd_cnt  <= 2'd0;
			req_ack <= 1'b0;
			status  <= '0;
			word_rx <= '0;
		end
		else
		begin
			req_ack <= accept_wr | accept_rd;
			// Acceptance clears the matching done bit
			if (accept_wr)
			begin
				wr_pend <= 1'b1;
				status[ST_TX_DONE] <= 1'b0;
			end
			if (accept_rd)
			begin
				rd_pend <= 1'b1;
				status[ST_RX_VALID] <= 1'b0;
			end
			case (state)
				IDLE:
				begin
					// Divisor first and then one byte per visit
					if (!div_set)
						state <= INIT_LO;
					else if (wr_pend && bus.tbr)
						state <= WRITE;
					else if (rd_pend && bus.rda)
						state <= READ;
				end
				INIT_LO:
					state <= INIT_HI;
				INIT_HI:
				begin
					div_set <= 1'b1;
					state   <= IDLE;
				end
				WRITE:
				begin
					wr_cnt <= wr_cnt + 1'b1;
					// Fourth byte handed to the core
					if (wr_cnt == 2'd3)
					begin
						wr_pend <= 1'b0;
						status[ST_TX_DONE] <= 1'b1;
					end
					state <= IDLE;
				end
				READ:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == 2'd3)
					begin
						rd_pend <= 1'b0;
						status[ST_RX_VALID] <= 1'b1;
						word_rx <= {bus.rdata, rx_asm[23:0]};
					end
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Word payload
	always_ff @(posedge clk)
	begin
		if (accept_wr)
			tx_word <= word_tx;
		if (state == READ)
			rx_asm[{rd_cnt, 3'b000} +: 8] <= bus.rdata;
	end

	//////////////////////////////////////////////////
	// Bus access decode
	//////////////////////////////////////////////////

	always_comb
	begin
		bus.iocs   = 1'b0;
		bus.iorw   = 1'b1;
		bus.ioaddr = ADDR_DATA;
		// LSB lane goes out first
		bus.wdata  = tx_word[{wr_cnt, 3'b000} +: 8];
		case (state)
			INIT_LO:
			begin
				bus.iocs   = 1'b1;
				bus.iorw   = 1'b0;
				bus.ioaddr = ADDR_DIV_LO;
				bus.wdata  = DIVISOR[7:0];
			end
			INIT_HI:
			begin
				bus.iocs   = 1'b1;
				bus.iorw   = 1'b0;
				bus.ioaddr = ADDR_DIV_HI;
				bus.wdata  = DIVISOR[15:8];
			end
			WRITE:
			begin
				bus.iocs = 1'b1;
				bus.iorw = 1'b0;
			end
			READ:
				bus.iocs = 1'b1;
			default:
				bus.iocs = 1'b0;
		endcase
	end

endmodule

//--- source/spart_pkg.sv
package spart_pkg;

	//////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////

	// Host word and bus byte
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  io_addr_t;
	typedef logic [15:0] div_t;

	// Bit 0 tx_done, bit 1 rx_valid
	typedef logic [1:0] word_status_t;
	localparam int ST_TX_DONE  = 0;
	localparam int ST_RX_VALID = 1;

	//////////////////////////////////////////////////
	// Register map and baud setup
	//////////////////////////////////////////////////

	localparam io_addr_t ADDR_DATA   = 2'd0;
	localparam io_addr_t ADDR_STATUS = 2'd1;
	localparam io_addr_t ADDR_DIV_LO = 2'd2;
	localparam io_addr_t ADDR_DIV_HI = 2'd3;

	// Clocks per 16x tick, so 64 clocks per bit
	localparam div_t DIVISOR    = 16'd4;
	localparam int   OVERSAMPLE = 16;

	// Tick counter inside one bit time
	typedef logic [$clog2(OVERSAMPLE)-1:0] tick_t;
	localparam tick_t TICK_MID  = tick_t'(OVERSAMPLE / 2 - 1);
	localparam tick_t TICK_LAST = tick_t'(OVERSAMPLE - 1);

	// State machines
	typedef enum logic [2:0] {INIT_LO, INIT_HI, IDLE, WRITE, READ} drv_state_t;
	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} ser_state_t;

endpackage

//--- source/spart_rx.sv
`timescale 1ns/1ns

module spart_rx import spart_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  tick,
	input  logic  rxd,
	output byte_t rx_byte,
	output logic  rx_done
);

	// Two-flop synchronizer
	logic rxd_s1;
	logic rxd_s2;

	ser_state_t state;
	tick_t      tick_cnt;
	logic [2:0] bit_cnt;
	byte_t      shreg;

	// Byte stays put until the next frame's data
	assign rx_byte = shreg;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
		end
		else
		begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= 3'd0;
			rx_done  <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					tick_cnt <= '0;
					// Falling edge, maybe a start bit
					if (!rxd_s2)
						state <= S_START;
				end
				S_START:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						// Mid-bit check, a glitch goes back to idle
						if (tick_cnt == TICK_MID)
						begin
							tick_cnt <= '0;
							bit_cnt  <= 3'd0;
							state    <= rxd_s2 ? S_IDLE : S_DATA;
						end
					end
				S_DATA:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= S_STOP;
						end
					end
				S_STOP:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
						begin
							// Framing error drops the byte
							rx_done <= rxd_s2;
							state   <= S_IDLE;
						end
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk)
	begin
		if (state == S_DATA && tick && tick_cnt == TICK_LAST)
			shreg <= {rxd_s2, shreg[7:1]};
	end

endmodule

//--- source/spart_system.sv
`timescale 1ns/1ns

module spart_system import spart_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         word_wr,
	input  logic         word_rd,
	input  word_t        word_tx,
	input  logic         rxd,
	output word_t        word_rx,
	output logic         req_ack,
	output word_status_t status,
	output logic         txd
);

	// Core internals
	div_t  div;
	logic  tick;
	byte_t tx_byte;
	logic  tx_load;
	logic  tx_busy;
	byte_t rx_byte;
	logic  rx_done;

	// Register bus between driver and core
	spart_bus_if u_bus ();

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	spart_driver u_driver (
		.clk     (clk),
		.rst     (rst),
		.word_wr (word_wr),
		.word_rd (word_rd),
		.word_tx (word_tx),
		.word_rx (word_rx),
		.req_ack (req_ack),
		.status  (status),
		.bus     (u_bus.drv)
	);

	//////////////////////////////////////////////////
	// SPART core
	//////////////////////////////////////////////////

	spart_bus_ctrl u_bus_ctrl (
		.clk     (clk),
		.rst     (rst),
		.tx_busy (tx_busy),
		.rx_byte (rx_byte),
		.rx_done (rx_done),
		.div     (div),
		.tx_byte (tx_byte),
		.tx_load (tx_load),
		.bus     (u_bus.dev)
	);

	spart_baud_gen u_baud_gen (
		.clk  (clk),
		.rst  (rst),
		.div  (div),
		.tick (tick)
	);

	spart_tx u_tx (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.tx_byte (tx_byte),
		.tx_load (tx_load),
		.tx_busy (tx_busy),
		.txd     (txd)
	);

	spart_rx u_rx (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.rxd     (rxd),
		.rx_byte (rx_byte),
		.rx_done (rx_done)
	);

endmodule

//--- source/spart_tx.sv
`timescale 1ns/1ns

module spart_tx import spart_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  tick,
	input  byte_t tx_byte,
	input  logic  tx_load,
	output logic  tx_busy,
	output logic  txd
);

	ser_state_t state;
	tick_t      tick_cnt;
	logic [2:0] bit_cnt;
	byte_t      shreg;

	assign tx_busy = (state != S_IDLE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= 3'd0;
			txd      <= 1'b1;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					txd <= 1'b1;
					// Start bit goes out right away
					if (tx_load)
					begin
						txd      <= 1'b0;
						tick_cnt <= '0;
						state    <= S_START;
					end
				end
				S_START:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
						begin
							txd     <= shreg[0];
							bit_cnt <= 3'd0;
							state   <= S_DATA;
						end
					end
				S_DATA:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
						begin
							// After bit 7 comes the stop bit
							if (bit_cnt == 3'd7)
							begin
								txd   <= 1'b1;
								state <= S_STOP;
							end
							else
							begin
								txd     <= shreg[1];
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				S_STOP:
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
							state <= S_IDLE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Shift register, LSB first
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && tx_load)
			shreg <= tx_byte;
		else if (state == S_DATA && tick && tick_cnt == TICK_LAST)
			shreg <= shreg >> 1;
	end

endmodule

//--- test/spart_system_chk.sv
`timescale 1ns/1ns

module spart_system_chk import spart_pkg::*; (
	input logic         clk,
	input logic         rst,
	input logic         word_wr,
	input logic         word_rd,
	input logic         req_ack,
	input word_status_t status,
	input logic         txd
);

	// One count per property
	int ack_twice_cnt  = 0;
	int ack_unreq_cnt  = 0;
	int status_cnt     = 0;
	int txd_rst_cnt    = 0;
	int fail_cnt;

	assign fail_cnt = ack_twice_cnt + ack_unreq_cnt + status_cnt + txd_rst_cnt;

	//////////////////////////////////////////////////
	// Host handshake
	//////////////////////////////////////////////////

	// Single-cycle acknowledge
	ack_single: assert property (@(posedge clk) disable iff (rst) req_ack |=> !req_ack)
	else
	begin
		$error("req_ack high for two cycles in a row");
		ack_twice_cnt++;
	end

	// Ack only follows a request
	ack_requested: assert property (@(posedge clk) disable iff (rst)
		req_ack |-> $past(word_wr || word_rd))
	else
	begin
		$error("req_ack without a request in the previous cycle");
		ack_unreq_cnt++;
	end

	// Done bits cannot rise as a request is taken
	status_no_rise: assert property (@(posedge clk) disable iff (rst)
		req_ack |-> !$rose(status[ST_TX_DONE]) && !$rose(status[ST_RX_VALID]))
	else
	begin
		$error("status bit rose in the cycle of an accepted request");
		status_cnt++;
	end

	//////////////////////////////////////////////////
	// Serial line
	//////////////////////////////////////////////////

	// Line idles high through reset
	txd_idle_rst: assert property (@(posedge clk) rst |=> txd)
	else
	begin
		$error("txd not high during reset");
		txd_rst_cnt++;
	end

endmodule

//--- test/spart_system_tb.sv
`timescale 1ns/1ns

module spart_system_tb import spart_pkg::*; ();

	// DUT ports
	logic         clk;
	logic         rst;
	logic         word_wr;
	logic         word_rd;
	word_t        word_tx;
	logic         rxd;
	word_t        word_rx;
	logic         req_ack;
	word_status_t status;
	logic         txd;

	// Clocks per serial bit
	int bit_clks = int'(DIVISOR) * OVERSAMPLE;

	// Bookkeeping
	int err_cnt      = 0;
	int err_at_start = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	// Bytes decoded from txd
	byte_t tx_bytes[$];

	// Last word sent by the far end
	word_t rx_word = '0;

	// Random state
	word_t lfsr = 32'h8a0c_ec7c;

	spart_system u_spart_system (
		.clk     (clk),
		.rst     (rst),
		.word_wr (word_wr),
		.word_rd (word_rd),
		.word_tx (word_tx),
		.rxd     (rxd),
		.word_rx (word_rx),
		.req_ack (req_ack),
		.status  (status),
		.txd     (txd)
	);

	bind spart_system spart_system_chk u_chk (
		.clk     (clk),
		.rst     (rst),
		.word_wr (word_wr),
		.word_rd (word_rd),
		.req_ack (req_ack),
		.status  (status),
		.txd     (txd)
	);

	always #5 clk = ~clk;

	// Watchdog allows 12 words of 4 frames twice over
	initial
	begin
		#(2 * 12 * 4 * 10 * bit_clks * 10);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input logic ok, input string msg);
		assert (ok === 1'b1)
		else
		begin
			$display("Fail at %0t ns: %s", $time, msg);
			err_cnt++;
		end
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic word_t lfsr_bits(input int n);
		word_t val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic report_test(input string name);
		tests_run++;
		if (err_cnt == err_at_start)
			$display("Test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, name);
		end
		err_at_start = err_cnt;
	endtask

	// One-cycle request with the ack checked one cycle later
	task automatic issue_request(input logic wr, input logic rd, input word_t data,
		input logic expect_ack);
		word_wr = wr;
		word_rd = rd;
		word_tx = data;
		@(negedge clk);
		word_wr = 1'b0;
		word_rd = 1'b0;
		check_value(req_ack == expect_ack,
			$sformatf("req_ack is %0b, expected %0b", req_ack, expect_ack));
	endtask

	task automatic start_write(input word_t w);
		issue_request(1'b1, 1'b0, w, 1'b1);
	endtask

	task automatic start_read();
		issue_request(1'b0, 1'b1, '0, 1'b1);
	endtask

	// Four frames on txd with the low byte first
	task automatic finish_write(input word_t w);
		byte_t b;
		while (tx_bytes.size() < 4)
			@(negedge clk);
		for (int i = 0; i < 4; i++)
		begin
			b = tx_bytes.pop_front();
			check_value(b == w[8*i +: 8],
				$sformatf("txd byte %0d is %h, expected %h", i, b, w[8*i +: 8]));
		end
		check_value(status[ST_TX_DONE], "tx_done not set after the last frame");
	endtask

	// 8N1 frame on rxd
	task automatic send_frame(input byte_t b);
		rxd = 1'b0;
		repeat (bit_clks) @(negedge clk);
		for (int i = 0; i < 8; i++)
		begin
			rxd = b[i];
			repeat (bit_clks) @(negedge clk);
		end
		rxd = 1'b1;
		repeat (bit_clks) @(negedge clk);
	endtask

	// Far end sends four random bytes
	task automatic finish_read();
		word_t exp;
		byte_t b;
		exp = '0;
		for (int i = 0; i < 4; i++)
		begin
			b = byte_t'(lfsr_bits(8));
			exp[8*i +: 8] = b;
			send_frame(b);
		end
		rx_word = exp;
		while (!status[ST_RX_VALID])
			@(negedge clk);
		check_value(word_rx == exp,
			$sformatf("word_rx is %h, expected %h", word_rx, exp));
	endtask

	//////////////////////////////////////////////////
	// Serial monitor
	//////////////////////////////////////////////////

	// Three samples per bit catch a short bit
	initial
	begin : txd_monitor
		byte_t b;
		logic  s0;
		logic  s1;
		logic  s2;
		forever
		begin
			@(negedge clk);
			if (!rst && txd === 1'b0)
			begin
				repeat (bit_clks / 2) @(negedge clk);
				check_value(txd === 1'b0, "start bit on txd too short");
				repeat (bit_clks / 2) @(negedge clk);
				for (int i = 0; i < 8; i++)
				begin
					repeat (bit_clks / 8) @(negedge clk);
					s0 = txd;
					repeat (3 * bit_clks / 8) @(negedge clk);
					s1 = txd;
					repeat (3 * bit_clks / 8) @(negedge clk);
					s2 = txd;
					repeat (bit_clks / 8) @(negedge clk);
					check_value(s0 == s1 && s1 == s2,
						$sformatf("txd bit %0d not held for a full bit time", i));
					b[i] = s1;
				end
				repeat (bit_clks / 2) @(negedge clk);
				check_value(txd === 1'b1, "stop bit on txd is not high");
				tx_bytes.push_back(b);
			end
		end
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial
	begin
		word_t w;
		int    total;
		clk     = 1'b0;
		rst     = 1'b1;
		word_wr = 1'b0;
		word_rd = 1'b0;
		word_tx = '0;
		rxd     = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle line and clear status without any ack
		repeat (20)
		begin
			check_value(txd === 1'b1 && status === '0 && req_ack === 1'b0,
				"outputs not idle after reset");
			@(negedge clk);
		end
		report_test("reset state");

		w = lfsr_bits(32);
		start_write(w);
		finish_write(w);
		report_test("word write");

		start_read();
		finish_read();
		report_test("word read");

		// Requests while a write is pending
		w = lfsr_bits(32);
		start_write(w);
		repeat (5) @(negedge clk);
		issue_request(1'b1, 1'b0, ~w, 1'b0);
		issue_request(1'b0, 1'b1, '0, 1'b0);
		finish_write(w);
		repeat (10 * bit_clks) @(negedge clk);
		check_value(tx_bytes.size() == 0, "extra frames on txd after a rejected write");
		check_value(word_rx == rx_word && status[ST_RX_VALID],
			"word_rx or rx_valid changed by a rejected read");
		// Requests while a read is pending
		start_read();
		repeat (5) @(negedge clk);
		issue_request(1'b1, 1'b0, ~w, 1'b0);
		issue_request(1'b0, 1'b1, '0, 1'b0);
		finish_read();
		check_value(tx_bytes.size() == 0 && txd === 1'b1,
			"txd active after a rejected write");
		report_test("busy rejection");

		// Each acceptance clears only its own bit
		check_value(status == 2'b11, $sformatf("status is %b, expected 11", status));
		w = lfsr_bits(32);
		start_write(w);
		check_value(!status[ST_TX_DONE] && status[ST_RX_VALID],
			$sformatf("status is %b after write accept, expected 10", status));
		finish_write(w);
		start_read();
		check_value(status[ST_TX_DONE] && !status[ST_RX_VALID],
			$sformatf("status is %b after read accept, expected 01", status));
		finish_read();
		report_test("status clearing");

		repeat (5)
		begin
			w = lfsr_bits(32);
			start_write(w);
			finish_write(w);
			start_read();
			finish_read();
		end
		report_test("random sequence");

		total = err_cnt + u_spart_system.u_chk.fail_cnt;
		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, total);
		if (tests_failed == 0 && total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
